//--- build.f
+incdir+design
design/ldst_rsp_pkg.sv
design/ldst_req_pkg.sv
design/ldst_pipe_arbiter.sv
design/ldst_decode.sv
design/ldst_execute.sv
design/ldst_result.sv
design/ldst_subsystem.sv
verif/ldst_checker.sv
verif/tb_ldst.sv

//--- verif/tb_ldst.sv
`timescale 1ns/100ps
`include "ldst_macros.svh"

module tb_ldst
	import ldst_req_pkg::*;
();

	localparam int WAIT_LIMIT = 200;	// Cycles allowed for any single wait
	localparam int MEM_BYTES  = 4 << `LDST_MEM_AW;

	logic                    clock;
	logic                    rst_n;
	logic                    use_sel;
	logic                    exe_req;
	ldst_req_t               exe_cmd;
	logic                    exe_busy;
	logic                    exe_valid;
	logic                    exe_fault;
	logic [`LDST_DATA_W-1:0] exe_data;
	logic                    except_req;
	ldst_req_t               except_cmd;
	logic                    except_busy;
	logic                    except_valid;
	logic [`LDST_DATA_W-1:0] except_data;
	logic                    exe_taken;
	logic                    except_taken;
	bit                      run_ok;
	int                      timeouts;
	int                      n;

	ldst_subsystem u_dut (.*);

	ldst_checker u_checker (.*);

	always #10 clock = ~clock;

	// Handshake as seen at the rising edge
	always @(posedge clock) begin
		exe_taken    = exe_req && !exe_busy;
		except_taken = except_req && !except_busy;
	end

	function automatic ldst_req_t make_cmd(ldst_order_e order, logic rw, int addr,
			logic [31:0] data);
		ldst_req_t c;
		c.order = order;
		c.rw    = rw;
		c.addr  = addr;
		c.data  = data;
		return c;
	endfunction

	function automatic ldst_req_t random_cmd();
		ldst_order_e order;
		int          addr;
		order = ldst_order_e'($urandom % 4);
		addr  = $urandom % MEM_BYTES;
		if ($urandom % 4 != 0)	// Mostly aligned
			addr = addr & ~((order == LDST_WORD) ? 3 : (order == LDST_HALF) ? 1 : 0);
		return make_cmd(order, $urandom % 2, addr, $urandom);
	endfunction

	task automatic fail_wait(input string what);
		$display("Timeout at %0t: %s", $time, what);
		timeouts++;
		run_ok = 0;
	endtask

	// Called on a falling edge and returns on the one after acceptance
	task automatic send_cmd(input bit sel, input ldst_req_t cmd);
		int i;
		bit done;
		done = 0;
		if (run_ok) begin
			use_sel    = sel;
			exe_req    = !sel;
			except_req = sel;
			exe_cmd    = cmd;
			except_cmd = cmd;
			for (i = 0; i < WAIT_LIMIT && !done; i++) begin
				@(negedge clock);
				done = sel ? except_taken : exe_taken;
			end
			if (!done)
				fail_wait("request was never accepted");
		end
	endtask

	task automatic run_directed();
		int i;
		for (i = 0; i < MEM_BYTES; i += 4)
			send_cmd(0, make_cmd(LDST_WORD, 0, i, 0));	// Cleared memory
		send_cmd(0, make_cmd(LDST_WORD, 1, 'h10, 'h1122_3344));
		send_cmd(1, make_cmd(LDST_HALF, 1, 'h16, 'h0000_beef));
		send_cmd(1, make_cmd(LDST_BYTE, 1, 'h13, 'h0000_00a5));
		for (i = 'h10; i < 'h18; i++) begin
			send_cmd(i[0], make_cmd(LDST_BYTE, 0, i, 0));
			send_cmd(!i[0], make_cmd(LDST_HALF, 0, i, 0));
			send_cmd(i[1], make_cmd(LDST_WORD, 0, i, 0));
		end
		// Misaligned and none stores leave memory unchanged
		send_cmd(0, make_cmd(LDST_HALF, 1, 'h11, 'hffff_ffff));
		send_cmd(0, make_cmd(LDST_WORD, 1, 'h12, 'hffff_ffff));
		send_cmd(1, make_cmd(LDST_NONE, 1, 'h10, 'hffff_ffff));
		send_cmd(0, make_cmd(LDST_NONE, 0, 'h10, 0));
		send_cmd(0, make_cmd(LDST_WORD, 0, 'h10, 0));
		send_cmd(0, make_cmd(LDST_WORD, 0, 'h14, 0));
		exe_req    = 0;
		except_req = 0;
	endtask

	task automatic run_random(input int cycles);
		int c;
		for (c = 0; c < cycles; c++) begin
			if ($urandom % 8 == 0)
				use_sel = !use_sel;
			if (!exe_req || exe_taken) begin	// Held until accepted
				exe_req = ($urandom % 4 != 0);
				exe_cmd = random_cmd();
			end
			if (!except_req || except_taken) begin
				except_req = ($urandom % 4 != 0);
				except_cmd = random_cmd();
			end
			@(negedge clock);
		end
		exe_req    = 0;
		except_req = 0;
	endtask

	initial begin
		int seed_val;
		clock        = 0;
		rst_n        = 0;
		use_sel      = 0;
		exe_req      = 0;
		exe_cmd      = '0;
		except_req   = 0;
		except_cmd   = '0;
		exe_taken    = 0;
		except_taken = 0;
		run_ok       = 1;
		timeouts     = 0;
		seed_val     = $urandom(32'hf94e_d612);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst_n = 1;
		for (n = 0; n < WAIT_LIMIT && exe_busy; n++)
			@(negedge clock);
		if (exe_busy)
			fail_wait("memory clear did not finish");
		run_directed();
		if (run_ok)
			run_random(2000);
		for (n = 0; n < WAIT_LIMIT && u_checker.outstanding != 0; n++)
			@(negedge clock);
		if (u_checker.outstanding != 0)
			fail_wait("responses still outstanding after the drain");
		u_checker.report_counts(timeouts);
		if (run_ok && u_checker.errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verif/ldst_checker.sv
`timescale 1ns/100ps
`include "ldst_macros.svh"

module ldst_checker
	import ldst_req_pkg::*;
(
	input logic                     clock,
	input logic                     rst_n,
	input logic                     use_sel,
	input logic                     exe_req,
	input ldst_req_t                exe_cmd,
	input logic                     exe_busy,
	input logic                     exe_valid,
	input logic                     exe_fault,
	input logic [`LDST_DATA_W-1:0] exe_data,
	input logic                     except_req,
	input ldst_req_t                except_cmd,
	input logic                     except_busy,
	input logic                     except_valid,
	input logic [`LDST_DATA_W-1:0] except_data
);

	localparam int CLEAR_CYCLES = 1 << `LDST_MEM_AW;
	localparam int MEM_BYTES    = 4 << `LDST_MEM_AW;

	typedef struct packed {
		logic [31:0]             due;	// Edge where the response is sampled
		logic                    fault;
		logic [`LDST_DATA_W-1:0] data;
	} expect_t;

	expect_t    exe_q[$];
	expect_t    except_q[$];
	logic [7:0] model_mem [MEM_BYTES];	// Little endian byte memory
	int         cycle;
	int         clear_edges;
	int         errors;
	int         checks;
	int         outstanding;

	initial begin
		int i;
		cycle = 0;
		clear_edges = 0;
		errors = 0;
		checks = 0;
		outstanding = 0;
		for (i = 0; i < MEM_BYTES; i++)
			model_mem[i] = '0;
	end

	// Model the access at its accept edge and queue what must come back
	task automatic record_accept(input bit own, input ldst_req_t cmd);
		expect_t e;
		int      size;
		int      a;
		int      i;
		a = cmd.addr[`LDST_MEM_AW+1:0];
		case (cmd.order)
			LDST_BYTE: size = 1;
			LDST_HALF: size = 2;
			LDST_WORD: size = 4;
			default:   size = 0;
		endcase
		e.due   = cycle + `LDST_PIPE_DEPTH;
		e.fault = (size > 1) && (a % size != 0);
		e.data  = '0;
		if (size != 0 && !e.fault) begin
			for (i = 0; i < size; i++) begin
				if (cmd.rw)
					model_mem[a + i] = cmd.data[8*i +: 8];
				else
					e.data[8*i +: 8] = model_mem[a + i];
			end
		end
		if (own)
			except_q.push_back(e);
		else
			exe_q.push_back(e);
	endtask

	task automatic check_response(input bit own, input logic valid, input logic fault,
			input logic [`LDST_DATA_W-1:0] data);
		expect_t e;
		bit      have;
		string   side;
		side = own ? "exception" : "execution";
		have = own ? (except_q.size() != 0) : (exe_q.size() != 0);
		if (have)
			e = own ? except_q[0] : exe_q[0];
		if (valid && !have) begin
			errors++;
			$display("Error at %0t: response on the %s port with nothing outstanding", $time, side);
		end else if (have && (valid || e.due <= cycle)) begin
			if (own)
				e = except_q.pop_front();
			else
				e = exe_q.pop_front();
			checks++;
			if (!valid) begin
				errors++;
				$display("Error at %0t: no response on the %s port at cycle %0d", $time, side,
					e.due);
			end else begin
				if (e.due != cycle) begin
					errors++;
					$display("Mismatch at %0t: %s response at cycle %0d, expected %0d", $time,
						side, cycle, e.due);
				end
				if (data !== e.data) begin
					errors++;
					$display("Mismatch at %0t: %s data %h, expected %h", $time, side, data,
						e.data);
				end
				if (!own && fault !== e.fault) begin	// Only execution has a fault output
					errors++;
					$display("Mismatch at %0t: fault %b, expected %b", $time, fault, e.fault);
				end
			end
		end
	endtask

	task automatic check_busy();
		if (clear_edges < CLEAR_CYCLES) begin
			clear_edges++;
			if (!exe_busy || !except_busy) begin
				errors++;
				$display("Mismatch at %0t: busy exe %b except %b during the memory clear",
					$time, exe_busy, except_busy);
			end
		end else if (exe_busy !== use_sel || except_busy !== ~use_sel) begin
			errors++;
			$display("Mismatch at %0t: busy exe %b except %b with use_sel %b", $time,
				exe_busy, except_busy, use_sel);
		end
	endtask

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cycle = 0;
			clear_edges = 0;
			exe_q.delete();
			except_q.delete();
			outstanding = 0;
		end else begin
			cycle++;
			check_busy();
			check_response(1'b0, exe_valid, exe_fault, exe_data);
			check_response(1'b1, except_valid, 1'b0, except_data);
			if (exe_req && !exe_busy)
				record_accept(1'b0, exe_cmd);
			if (except_req && !except_busy)
				record_accept(1'b1, except_cmd);
			outstanding = exe_q.size() + except_q.size();
		end
	end

	task automatic report_counts(input int timeouts);
		$display("Responses checked %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
	endtask

endmodule

//--- design/ldst_subsystem.sv
`timescale 1ns/100ps
`default_nettype none
`include "ldst_macros.svh"

module ldst_subsystem
	import ldst_req_pkg::*;
	import ldst_rsp_pkg::*;
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     use_sel,
	input  logic                     exe_req,
	input  ldst_req_t                exe_cmd,
	output logic                     exe_busy,
	output logic                     exe_valid,
	output logic                     exe_fault,
	output logic [`LDST_DATA_W-1:0] exe_data,
	input  logic                     except_req,
	input  ldst_req_t                except_cmd,
	output logic                     except_busy,
	output logic                     except_valid,
	output logic [`LDST_DATA_W-1:0] except_data
);

	logic                    acc_req;
	ldst_req_t               acc_cmd;
	ldst_owner_e             acc_owner;
	logic                    mem_busy;
	logic                    dec_valid;
	ldst_access_t            dec_acc;
	logic                    ex_valid;	// Execute stage out
	ldst_access_t            ex_acc;
	logic [`LDST_DATA_W-1:0] rd_word;
	logic                    rsp_valid;
	ldst_rsp_t               rsp;

	ldst_pipe_arbiter u_arbiter (
		.clock        (clock),
		.rst_n        (rst_n),
		.use_sel      (use_sel),
		.exe_req      (exe_req),
		.exe_cmd      (exe_cmd),
		.exe_busy     (exe_busy),
		.exe_valid    (exe_valid),
		.exe_fault    (exe_fault),
		.exe_data     (exe_data),
		.except_req   (except_req),
		.except_cmd   (except_cmd),
		.except_busy  (except_busy),
		.except_valid (except_valid),
		.except_data  (except_data),
		.acc_req      (acc_req),
		.acc_cmd      (acc_cmd),
		.acc_owner    (acc_owner),
		.mem_busy     (mem_busy),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp)
	);

	ldst_decode u_decode (
		.clock     (clock),
		.rst_n     (rst_n),
		.acc_req   (acc_req),
		.acc_cmd   (acc_cmd),
		.acc_owner (acc_owner),
		.mem_busy  (mem_busy),
		.dec_valid (dec_valid),
		.dec_acc   (dec_acc)
	);

	ldst_execute u_execute (
		.clock     (clock),
		.rst_n     (rst_n),
		.dec_valid (dec_valid),
		.dec_acc   (dec_acc),
		.mem_busy  (mem_busy),
		.exe_valid (ex_valid),
		.exe_acc   (ex_acc),
		.rd_word   (rd_word)
	);

	ldst_result u_result (
		.clock     (clock),
		.rst_n     (rst_n),
		.exe_valid (ex_valid),
		.exe_acc   (ex_acc),
		.rd_word   (rd_word),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

//--- design/ldst_result.sv
`timescale 1ns/100ps
`default_nettype none
`include "ldst_macros.svh"

module ldst_result
	import ldst_req_pkg::*;
	import ldst_rsp_pkg::*;
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     exe_valid,
	input  ldst_access_t             exe_acc,
	input  logic [`LDST_DATA_W-1:0] rd_word,
	output logic                     rsp_valid,
	output ldst_rsp_t                rsp
);

	logic [`LDST_DATA_W-1:0] shifted;
	logic [`LDST_DATA_W-1:0] ld_data;

	// Bring the addressed lane down to bit 0
	assign shifted = rd_word >> {exe_acc.lo, 3'b000};

	always_comb begin
		case (exe_acc.order)
			LDST_BYTE: ld_data = {{(`LDST_DATA_W-8){1'b0}}, shifted[7:0]};
			LDST_HALF: ld_data = {{(`LDST_DATA_W-16){1'b0}}, shifted[15:0]};
			LDST_WORD: ld_data = shifted;
			default:   ld_data = '0;	// None
		endcase

		// Stores and faults return nothing
		if (exe_acc.rw || exe_acc.fault)
			ld_data = '0;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= exe_valid;
	end

	always_ff @(posedge clock) begin
		if (exe_valid) begin
			rsp.owner <= exe_acc.owner;
			rsp.fault <= exe_acc.fault;
			rsp.data  <= ld_data;
		end
	end

	a_fault_zero: assert property (
		@(posedge clock) disable iff (!rst_n)
		(rsp_valid && rsp.fault) |-> (rsp.data == '0)
	) else $error("Fault response with nonzero data");

endmodule

`default_nettype wire

//--- design/ldst_execute.sv
`timescale 1ns/100ps
`default_nettype none
`include "ldst_macros.svh"

module ldst_execute
	import ldst_req_pkg::*;
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     dec_valid,
	input  ldst_access_t             dec_acc,
	output logic                     mem_busy,
	output logic                     exe_valid,
	output ldst_access_t             exe_acc,
	output logic [`LDST_DATA_W-1:0] rd_word
);

	localparam int LANES = `LDST_DATA_W / 8;
	localparam int DEPTH = 1 << `LDST_MEM_AW;

	logic [`LDST_DATA_W-1:0] mem [DEPTH];

	logic [`LDST_MEM_AW-1:0] clr_idx;
	logic                    clr_active;	// Sweep running

	assign mem_busy = clr_active;

	// Clear sweep, one word per cycle after reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			clr_active <= 1'b1;
			clr_idx    <= '0;
		end else if (clr_active) begin
			clr_idx <= clr_idx + 1'b1;
			if (&clr_idx)
				clr_active <= 1'b0;	// Last word done
		end
	end

	// Memory port
	always_ff @(posedge clock) begin
		if (clr_active) begin
			mem[clr_idx] <= '0;
		end else if (dec_valid) begin
			if (dec_acc.rw) begin
				for (int i = 0; i < LANES; i++) begin
					if (dec_acc.be[i])
						mem[dec_acc.word_idx][8*i +: 8] <= dec_acc.wdata[8*i +: 8];
				end
			end
			rd_word <= mem[dec_acc.word_idx];	// Old data on a write, unused then
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			exe_valid <= 1'b0;
		else
			exe_valid <= dec_valid;
	end

	always_ff @(posedge clock) begin
		if (dec_valid)
			exe_acc <= dec_acc;
	end

endmodule

`default_nettype wire

//--- design/ldst_decode.sv
`timescale 1ns/100ps
`default_nettype none
`include "ldst_macros.svh"

module ldst_decode
	import ldst_req_pkg::*;
	import ldst_rsp_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	input  logic         acc_req,
	input  ldst_req_t    acc_cmd,
	input  ldst_owner_e  acc_owner,
	input  logic         mem_busy,
	output logic         dec_valid,
	output ldst_access_t dec_acc
);

	ldst_access_t acc_next;
	logic         accept;

	assign accept = acc_req && !mem_busy;

	always_comb begin
		acc_next          = '0;
		acc_next.owner    = acc_owner;
		acc_next.rw       = acc_cmd.rw;
		acc_next.order    = acc_cmd.order;
		acc_next.lo       = acc_cmd.addr[1:0];
		acc_next.word_idx = acc_cmd.addr[`LDST_MEM_AW+1:2];
		acc_next.wdata    = acc_cmd.data << {acc_cmd.addr[1:0], 3'b000};	// Onto lanes

		case (acc_cmd.order)
			LDST_BYTE: begin
				acc_next.be = 4'b0001 << acc_cmd.addr[1:0];
			end
			LDST_HALF: begin
				acc_next.fault = acc_cmd.addr[0];	// Odd address
				acc_next.be    = 4'b0011 << acc_cmd.addr[1:0];
			end
			LDST_WORD: begin
				acc_next.fault = |acc_cmd.addr[1:0];
				acc_next.be    = 4'b1111;
			end
			default: acc_next.be = '0;	// None touches no lanes
		endcase

		// Faulting access must not write
		if (acc_next.fault)
			acc_next.be = '0;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= accept;
	end

	always_ff @(posedge clock) begin
		if (accept)
			dec_acc <= acc_next;
	end

	// Memory clear must block the pipe entry
	a_no_accept_busy: assert property (
		@(posedge clock) disable iff (!rst_n)
		mem_busy |=> !dec_valid
	) else $error("Request decoded during memory clear");

endmodule

`default_nettype wire

//--- design/ldst_pipe_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "ldst_macros.svh"

module ldst_pipe_arbiter
	import ldst_req_pkg::*;
	import ldst_rsp_pkg::*;
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     use_sel,	// 0 execution, 1 exception
	// Execution unit
	input  logic                     exe_req,
	input  ldst_req_t                exe_cmd,
	output logic                     exe_busy,
	output logic                     exe_valid,
	output logic                     exe_fault,
	output logic [`LDST_DATA_W-1:0] exe_data,
	// Exception unit
	input  logic                     except_req,
	input  ldst_req_t                except_cmd,
	output logic                     except_busy,
	output logic                     except_valid,
	output logic [`LDST_DATA_W-1:0] except_data,
	// Pipeline side
	output logic                     acc_req,
	output ldst_req_t                acc_cmd,
	output ldst_owner_e              acc_owner,
	input  logic                     mem_busy,
	input  logic                     rsp_valid,
	input  ldst_rsp_t                rsp
);

	// Request mux on the selector
	assign acc_req   = use_sel ? except_req : exe_req;
	assign acc_cmd   = use_sel ? except_cmd : exe_cmd;
	assign acc_owner = use_sel ? LDST_OWN_EXCEPT : LDST_OWN_EXE;

	// Idle side always sees busy
	assign exe_busy    = use_sel ? 1'b1 : mem_busy;
	assign except_busy = use_sel ? mem_busy : 1'b1;

	// Responses follow the owner tag, not use_sel, so a switch mid-flight is safe
	assign exe_valid    = rsp_valid && (rsp.owner == LDST_OWN_EXE);
	assign except_valid = rsp_valid && (rsp.owner == LDST_OWN_EXCEPT);
	assign exe_fault    = exe_valid && rsp.fault;	// Exception side has no fault
	assign exe_data     = rsp.data;
	assign except_data  = rsp.data;

	a_one_owner: assert property (
		@(posedge clock) disable iff (!rst_n)
		!(exe_valid && except_valid)
	) else $error("Response driven to both requesters");

	// Every accepted request comes back to its owner after the full pipe
	a_rsp_latency: assert property (
		@(posedge clock) disable iff (!rst_n)
		(acc_req && !mem_busy) |-> ##(`LDST_PIPE_DEPTH)
			(rsp_valid && rsp.owner == $past(acc_owner, `LDST_PIPE_DEPTH))
	) else $error("Response missing or misrouted");

endmodule

`default_nettype wire

//--- design/ldst_req_pkg.sv
`include "ldst_macros.svh"

package ldst_req_pkg;

	// Access size, same encoding as the core bus
	typedef enum logic [1:0] {
		LDST_BYTE = 2'b00,
		LDST_HALF = 2'b01,
		LDST_WORD = 2'b10,
		LDST_NONE = 2'b11
	} ldst_order_e;

	// Request as presented by a requester
	typedef struct packed {
		ldst_order_e              order;
		logic                     rw;	// 1 = write
		logic [`LDST_DATA_W-1:0] addr;
		logic [`LDST_DATA_W-1:0] data;
	} ldst_req_t;

	// Request after decode, ready for the memory stage
	typedef struct packed {
		ldst_rsp_pkg::ldst_owner_e  owner;
		logic                       rw;
		ldst_order_e                order;
		logic [1:0]                 lo;	// Byte offset in the word
		logic [`LDST_MEM_AW-1:0]    word_idx;
		logic [`LDST_DATA_W/8-1:0] be;	// Byte enables, zero on fault or none
		logic [`LDST_DATA_W-1:0]   wdata;	// Store data on its lanes
		logic                       fault;
	} ldst_access_t;

endpackage

//--- design/ldst_rsp_pkg.sv
`include "ldst_macros.svh"

package ldst_rsp_pkg;

	// Which unit issued the request
	typedef enum logic {
		LDST_OWN_EXE    = 1'b0,	// Execution unit
		LDST_OWN_EXCEPT = 1'b1	// Exception unit
	} ldst_owner_e;

	// Response from the result stage, routed by owner
	typedef struct packed {
		ldst_owner_e              owner;
		logic                     fault;	// Misaligned access
		logic [`LDST_DATA_W-1:0] data;	// Zero-extended load data
	} ldst_rsp_t;

endpackage

//--- design/ldst_macros.svh
`ifndef LDST_MACROS_SVH
`define LDST_MACROS_SVH

// Data path and address width
`define LDST_DATA_W 32

// Word address bits of the internal memory, 64 words
`define LDST_MEM_AW 6

// Cycles from the accept edge to the response
`define LDST_PIPE_DEPTH 3

`endif
